//--- build.f
design/cpu_pkg.sv
design/pipe_reg.sv
design/fetch_unit.sv
design/reg_file.sv
design/inst_decode.sv
design/exec_unit.sv
design/mem_arbiter.sv
design/hazard_ctrl.sv
design/cpu_core_top.sv
dv/tb_cpu_core.sv

//--- design/cpu_core_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core_top import cpu_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    output mem_req_t        mem_req,
    input  logic [xlen-1:0] mem_rdata,
    output ex_wb_t          retire
);

    mem_req_t        fetch_req;
    mem_req_t        data_req;
    logic [xlen-1:0] fetch_rdata;
    logic [xlen-1:0] data_rdata;
    logic            fetch_gnt;
    logic            pc_hold;
    logic            if_id_flush;
    logic            id_ex_flush;
    logic            redirect;
    logic [xlen-1:0] redirect_pc;
    fwd_sel_e        fwd_a;
    fwd_sel_e        fwd_b;
    if_id_t          if_id_d;
    if_id_t          if_id_q;
    id_ex_t          id_ex_d;
    id_ex_t          id_ex_q;
    ex_wb_t          ex_wb_d;
    reg_addr_t       rs;
    reg_addr_t       rt;
    logic [xlen-1:0] rs_data;
    logic [xlen-1:0] rt_data;

    //////////////////////////////
    // Fetch and decode
    //////////////////////////////
    fetch_unit u_fetch (
        .clk(clk), .arst_n(arst_n), .pc_hold(pc_hold), .redirect(redirect),
        .redirect_pc(redirect_pc), .fetch_req(fetch_req),
        .fetch_rdata(fetch_rdata), .if_id_d(if_id_d)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk(clk), .arst_n(arst_n), .stall(1'b0), .flush(if_id_flush),
        .d(if_id_d), .q(if_id_q)
    );

    inst_decode u_decode (
        .if_id(if_id_q), .rs(rs), .rt(rt), .rs_data(rs_data),
        .rt_data(rt_data), .id_ex_d(id_ex_d)
    );

    reg_file u_regs (
        .clk(clk), .arst_n(arst_n), .rs(rs), .rt(rt), .rs_data(rs_data),
        .rt_data(rt_data), .wb(retire)
    );

    //////////////////////////////
    // Execute and writeback
    //////////////////////////////
    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .arst_n(arst_n), .stall(1'b0), .flush(id_ex_flush),
        .d(id_ex_d), .q(id_ex_q)
    );

    exec_unit u_exec (
        .id_ex(id_ex_q), .fwd_a(fwd_a), .fwd_b(fwd_b), .wb_result(retire.result),
        .data_req(data_req), .data_rdata(data_rdata), .redirect(redirect),
        .redirect_pc(redirect_pc), .ex_wb_d(ex_wb_d)
    );

    // EX/WB is never flushed, a retiring instruction always completes
    pipe_reg #(.payload_t(ex_wb_t)) u_ex_wb (
        .clk(clk), .arst_n(arst_n), .stall(1'b0), .flush(1'b0),
        .d(ex_wb_d), .q(retire)
    );

    mem_arbiter u_arb (
        .fetch_req(fetch_req), .data_req(data_req), .mem_req(mem_req),
        .mem_rdata(mem_rdata), .fetch_rdata(fetch_rdata),
        .data_rdata(data_rdata), .fetch_gnt(fetch_gnt)
    );

    hazard_ctrl u_hazard (
        .fetch_gnt(fetch_gnt), .redirect(redirect), .id_ex(id_ex_q),
        .ex_wb(retire), .pc_hold(pc_hold), .if_id_flush(if_id_flush),
        .id_ex_flush(id_ex_flush), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

endmodule

`default_nettype wire

//--- design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    //////////////////////////////
    // Widths and reset values
    //////////////////////////////
    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = '0;

    typedef logic [4:0] reg_addr_t;

    // Opcode field, bits 31:26
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_j     = 6'h02;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    // Funct field for R-type
    localparam logic [5:0] funct_add = 6'h20;
    localparam logic [5:0] funct_sub = 6'h22;
    localparam logic [5:0] funct_and = 6'h24;
    localparam logic [5:0] funct_or  = 6'h25;
    localparam logic [5:0] funct_slt = 6'h2a;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_e;

    typedef enum logic {
        fwd_reg,
        fwd_wb
    } fwd_sel_e;

    //////////////////////////////
    // Bus and stage payloads
    //////////////////////////////
    typedef struct packed {
        logic            rd_stb;
        logic            wr_stb;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc_4;
        logic [xlen-1:0] op_a;
        logic [xlen-1:0] op_b;
        logic [xlen-1:0] imm_ext;
        reg_addr_t       rs;
        reg_addr_t       rt;
        reg_addr_t       rd;
        alu_op_e         alu_op;
        logic            b_sel;
        logic            reg_w;
        logic            mem_r;
        logic            mem_w;
        logic            branch;
        logic            jmp;
        logic [xlen-1:0] jmp_target;
    } id_ex_t;

    // Also serves as the retire record
    typedef struct packed {
        logic            valid;
        logic            reg_w;
        reg_addr_t       rd;
        logic [xlen-1:0] result;
    } ex_wb_t;

endpackage

`default_nettype wire

//--- design/exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

module exec_unit import cpu_pkg::*; (
    input  id_ex_t          id_ex,
    input  fwd_sel_e        fwd_a,
    input  fwd_sel_e        fwd_b,
    input  logic [xlen-1:0] wb_result,
    output mem_req_t        data_req,
    input  logic [xlen-1:0] data_rdata,
    output logic            redirect,
    output logic [xlen-1:0] redirect_pc,
    output ex_wb_t          ex_wb_d
);

    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] br_target;

    assign src_a = (fwd_a == fwd_wb) ? wb_result : id_ex.op_a;
    assign src_b = (fwd_b == fwd_wb) ? wb_result : id_ex.op_b;
    assign alu_b = id_ex.b_sel ? id_ex.imm_ext : src_b;

    always_comb begin
        case (id_ex.alu_op)
            alu_sub: alu_res = src_a - alu_b;
            alu_and: alu_res = src_a & alu_b;
            alu_or:  alu_res = src_a | alu_b;
            alu_slt: alu_res = {31'd0, $signed(src_a) < $signed(alu_b)};
            default: alu_res = src_a + alu_b;
        endcase
    end

    // Branch offset counts words
    assign br_target   = id_ex.pc_4 + {id_ex.imm_ext[xlen-3:0], 2'b00};
    assign redirect    = id_ex.valid && (id_ex.jmp || (id_ex.branch && src_a == src_b));
    assign redirect_pc = id_ex.jmp ? id_ex.jmp_target : br_target;

    always_comb begin
        data_req.rd_stb = id_ex.valid && id_ex.mem_r;
        data_req.wr_stb = id_ex.valid && id_ex.mem_w;
        data_req.addr   = {alu_res[xlen-1:2], 2'b00};
        data_req.wdata  = src_b;
    end

    always_comb begin
        ex_wb_d.valid  = id_ex.valid;
        ex_wb_d.reg_w  = id_ex.reg_w;
        ex_wb_d.rd     = id_ex.rd;
        ex_wb_d.result = id_ex.mem_r ? data_rdata : alu_res;
    end

    // Decode never marks one instruction as both load and store
    always_comb begin
        one_mem_op: assert final (!(id_ex.valid === 1'b1 && id_ex.mem_r === 1'b1 &&
                                    id_ex.mem_w === 1'b1))
            else $error("exec_unit got load and store together");
    end

endmodule

`default_nettype wire

//--- design/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit import cpu_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            pc_hold,
    input  logic            redirect,
    input  logic [xlen-1:0] redirect_pc,
    output mem_req_t        fetch_req,
    input  logic [xlen-1:0] fetch_rdata,
    output if_id_t          if_id_d
);

    logic [xlen-1:0] pc;

    // Redirect beats a hold from a lost grant
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!pc_hold) begin
            pc <= pc + 32'd4;
        end
    end

    // Read at pc every cycle
    always_comb begin
        fetch_req        = '0;
        fetch_req.rd_stb = 1'b1;
        fetch_req.addr   = pc;
    end

    always_comb begin
        if_id_d.valid = 1'b1;
        if_id_d.pc    = pc;
        if_id_d.instr = fetch_rdata;
    end

endmodule

`default_nettype wire

//--- design/hazard_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_ctrl import cpu_pkg::*; (
    input  logic     fetch_gnt,
    input  logic     redirect,
    input  id_ex_t   id_ex,
    input  ex_wb_t   ex_wb,
    output logic     pc_hold,
    output logic     if_id_flush,
    output logic     id_ex_flush,
    output fwd_sel_e fwd_a,
    output fwd_sel_e fwd_b
);

    logic wb_writes;

    // Lost grant means nothing valid was fetched
    assign pc_hold     = !fetch_gnt;
    assign if_id_flush = !fetch_gnt || redirect;
    assign id_ex_flush = redirect;

    // Only a live write to a nonzero register is worth forwarding
    assign wb_writes = ex_wb.valid && ex_wb.reg_w && (ex_wb.rd != '0);

    always_comb begin
        fwd_a = fwd_reg;
        fwd_b = fwd_reg;
        if (wb_writes && ex_wb.rd == id_ex.rs) begin
            fwd_a = fwd_wb;
        end
        if (wb_writes && ex_wb.rd == id_ex.rt) begin
            fwd_b = fwd_wb;
        end
    end

endmodule

`default_nettype wire

//--- design/inst_decode.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decode import cpu_pkg::*; (
    input  if_id_t          if_id,
    output reg_addr_t       rs,
    output reg_addr_t       rt,
    input  logic [xlen-1:0] rs_data,
    input  logic [xlen-1:0] rt_data,
    output id_ex_t          id_ex_d
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rd_field;
    logic       known;

    assign opcode   = if_id.instr[31:26];
    assign funct    = if_id.instr[5:0];
    assign rs       = if_id.instr[25:21];
    assign rt       = if_id.instr[20:16];
    assign rd_field = if_id.instr[15:11];

    always_comb begin
        known              = 1'b1;
        id_ex_d            = '0;
        id_ex_d.pc_4       = if_id.pc + 32'd4;
        id_ex_d.op_a       = rs_data;
        id_ex_d.op_b       = rt_data;
        id_ex_d.imm_ext    = {{16{if_id.instr[15]}}, if_id.instr[15:0]};
        id_ex_d.rs         = rs;
        id_ex_d.rt         = rt;
        id_ex_d.jmp_target = {id_ex_d.pc_4[31:28], if_id.instr[25:0], 2'b00};

        case (opcode)
            op_rtype: begin
                id_ex_d.reg_w = 1'b1;
                id_ex_d.rd    = rd_field;
                case (funct)
                    funct_add: id_ex_d.alu_op = alu_add;
                    funct_sub: id_ex_d.alu_op = alu_sub;
                    funct_and: id_ex_d.alu_op = alu_and;
                    funct_or:  id_ex_d.alu_op = alu_or;
                    funct_slt: id_ex_d.alu_op = alu_slt;
                    default:   known = 1'b0;
                endcase
            end
            op_addi, op_lw: begin
                id_ex_d.reg_w = 1'b1;
                id_ex_d.b_sel = 1'b1;
                id_ex_d.mem_r = (opcode == op_lw);
                id_ex_d.rd    = rt;
            end
            op_sw: begin
                id_ex_d.b_sel = 1'b1;
                id_ex_d.mem_w = 1'b1;
            end
            op_beq:  id_ex_d.branch = 1'b1;
            op_j:    id_ex_d.jmp = 1'b1;
            default: known = 1'b0;
        endcase

        // Empty slot or unknown encoding leaves a clean bubble
        id_ex_d.valid = if_id.valid && known;
        if (!id_ex_d.valid) begin
            id_ex_d = '0;
        end
    end

endmodule

`default_nettype wire

//--- design/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter import cpu_pkg::*; (
    input  mem_req_t        fetch_req,
    input  mem_req_t        data_req,
    output mem_req_t        mem_req,
    input  logic [xlen-1:0] mem_rdata,
    output logic [xlen-1:0] fetch_rdata,
    output logic [xlen-1:0] data_rdata,
    output logic            fetch_gnt
);

    logic data_active;

    assign data_active = data_req.rd_stb || data_req.wr_stb;

    // Data side has priority, fetch retries next cycle
    assign fetch_gnt = !data_active;

    always_comb begin
        if (data_active) begin
            mem_req = data_req;
        end else begin
            mem_req = fetch_req;
        end
    end

    // Same-cycle memory, read data simply fans out
    assign fetch_rdata = mem_rdata;
    assign data_rdata  = mem_rdata;

    // Bus never sees read and write in one cycle
    always_comb begin
        strobe_excl: assert final (!(mem_req.rd_stb === 1'b1 && mem_req.wr_stb === 1'b1))
            else $error("memory bus has read and write strobes together");
    end

endmodule

`default_nettype wire

//--- design/pipe_reg.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Stall wins over flush, a flushed stage becomes an all-zero bubble
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (flush && !stall) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

    // A stalled stage keeps its payload across the edge
    hold_on_stall: assert property (
        @(posedge clk) disable iff (!arst_n)
        stall |=> $stable(q)
    ) else $error("pipe_reg payload changed under stall");

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  reg_addr_t       rs,
    input  reg_addr_t       rt,
    output logic [xlen-1:0] rs_data,
    output logic [xlen-1:0] rt_data,
    input  ex_wb_t          wb
);

    logic [xlen-1:0] regs [32];
    logic            wr_en;

    assign wr_en = wb.valid && wb.reg_w;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // Write-through so decode sees the retiring value
    assign rs_data = (rs == '0) ? '0 :
                     (wr_en && wb.rd == rs) ? wb.result : regs[rs];
    assign rt_data = (rt == '0) ? '0 :
                     (wr_en && wb.rd == rt) ? wb.result : regs[rt];

endmodule

`default_nettype wire

//--- dv/tb_cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_core import cpu_pkg::*; ();

    logic            clk;
    logic            arst_n;
    mem_req_t        mem_req;
    logic [xlen-1:0] mem_rdata;
    ex_wb_t          retire;

    logic [xlen-1:0] mem_words [1024];
    logic [xlen-1:0] model_regs [32];
    logic [xlen-1:0] model_mem [1024];
    ex_wb_t          exp_retire_q [$];
    ex_wb_t          got_retire_q [$];
    mem_req_t        exp_store_q [$];
    mem_req_t        got_store_q [$];
    int              prog_len;
    int              mismatch_cnt;
    int              fail_cnt;

    cpu_core_top u_dut (
        .clk(clk), .arst_n(arst_n), .mem_req(mem_req),
        .mem_rdata(mem_rdata), .retire(retire)
    );

    always #50 clk = ~clk;

    //////////////////////////////
    // Memory model and monitor
    //////////////////////////////
    assign mem_rdata = mem_words[mem_req.addr[11:2]];

    always @(posedge clk) begin
        if (mem_req.wr_stb) begin
            mem_words[mem_req.addr[11:2]] <= mem_req.wdata;
        end
    end

    // Outputs are settled mid-cycle
    always @(negedge clk) begin
        if (arst_n && retire.valid) begin
            got_retire_q.push_back(retire);
        end
        if (arst_n && mem_req.wr_stb) begin
            got_store_q.push_back(mem_req);
        end
    end

    //////////////////////////////
    // Program building
    //////////////////////////////
    function automatic logic [xlen-1:0] sext16(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    task automatic put_word(logic [31:0] w);
        mem_words[prog_len] = w;
        prog_len++;
    endtask

    task automatic expect_retire(logic reg_w, reg_addr_t rd, logic [xlen-1:0] value);
        ex_wb_t rec;
        rec.valid  = 1'b1;
        rec.reg_w  = reg_w;
        rec.rd     = rd;
        rec.result = value;
        exp_retire_q.push_back(rec);
        // r0 stays zero whatever is written
        if (reg_w && rd != 5'd0) begin
            model_regs[rd] = value;
        end
    endtask

    task automatic addi_instr(reg_addr_t rt, reg_addr_t rs, logic [15:0] imm);
        put_word({op_addi, rs, rt, imm});
        expect_retire(1'b1, rt, model_regs[rs] + sext16(imm));
    endtask

    task automatic rtype_instr(logic [5:0] funct, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] value;
        a = model_regs[rs];
        b = model_regs[rt];
        case (funct)
            funct_sub: value = a - b;
            funct_and: value = a & b;
            funct_or:  value = a | b;
            funct_slt: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:   value = a + b;
        endcase
        put_word({op_rtype, rs, rt, rd, 5'd0, funct});
        expect_retire(1'b1, rd, value);
    endtask

    task automatic store_instr(reg_addr_t rt, reg_addr_t rs, logic [15:0] off);
        mem_req_t req;
        req        = '0;
        req.wr_stb = 1'b1;
        req.addr   = model_regs[rs] + sext16(off);
        req.wdata  = model_regs[rt];
        exp_store_q.push_back(req);
        model_mem[req.addr[11:2]] = req.wdata;
        put_word({op_sw, rs, rt, off});
        expect_retire(1'b0, 5'd0, '0);
    endtask

    task automatic load_instr(reg_addr_t rt, reg_addr_t rs, logic [15:0] off);
        logic [xlen-1:0] addr;
        logic [xlen-1:0] value;
        addr  = model_regs[rs] + sext16(off);
        value = model_mem[addr[11:2]];
        put_word({op_lw, rs, rt, off});
        expect_retire(1'b1, rt, value);
    endtask

    // Control flow writes no register
    task automatic beq_instr(reg_addr_t rs, reg_addr_t rt, logic [15:0] off);
        put_word({op_beq, rs, rt, off});
        expect_retire(1'b0, 5'd0, '0);
    endtask

    task automatic jump_instr(int target_word);
        put_word({op_j, 26'(target_word)});
        expect_retire(1'b0, 5'd0, '0);
    endtask

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic check_retire(string name, ex_wb_t got, ex_wb_t exp);
        logic same;
        if (exp.reg_w) begin
            same = (got === exp);
        end else begin
            same = (got.valid === exp.valid) && (got.reg_w === exp.reg_w);
        end
        if (!same) begin
            mismatch_cnt++;
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_req(string name, mem_req_t got, mem_req_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    //////////////////////////////
    // Run control
    //////////////////////////////
    task automatic load_begin();
        @(posedge clk);
        #1 arst_n = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            mem_words[i] = '0;
            model_mem[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        exp_retire_q.delete();
        got_retire_q.delete();
        exp_store_q.delete();
        got_store_q.delete();
        prog_len = 0;
        repeat (5) @(posedge clk);
    endtask

    task automatic release_reset();
        #1 arst_n = 1'b1;
    endtask

    task automatic check_results(string tname);
        int cycles;
        int n;
        cycles = 0;
        while (got_retire_q.size() < exp_retire_q.size() && cycles < 200) begin
            @(posedge clk);
            cycles++;
        end
        if (got_retire_q.size() < exp_retire_q.size()) begin
            fail_cnt++;
            $display("%s: timed out waiting for %0d retires, only %0d seen",
                     tname, exp_retire_q.size(), got_retire_q.size());
        end
        // Extra window so a wrongly executed instruction still shows up
        cycles = 0;
        while (cycles < 8) begin
            @(posedge clk);
            cycles++;
        end
        if (got_retire_q.size() > exp_retire_q.size()) begin
            fail_cnt++;
            $display("%s: %0d instructions retired, only %0d expected",
                     tname, got_retire_q.size(), exp_retire_q.size());
        end
        if (got_store_q.size() != exp_store_q.size()) begin
            fail_cnt++;
            $display("%s: saw %0d stores on the bus, expected %0d",
                     tname, got_store_q.size(), exp_store_q.size());
        end
        n = (got_retire_q.size() < exp_retire_q.size()) ? got_retire_q.size()
                                                        : exp_retire_q.size();
        for (int i = 0; i < n; i++) begin
            check_retire($sformatf("%s retire[%0d]", tname, i), got_retire_q[i], exp_retire_q[i]);
        end
        n = (got_store_q.size() < exp_store_q.size()) ? got_store_q.size() : exp_store_q.size();
        for (int i = 0; i < n; i++) begin
            check_req($sformatf("%s mem_req[%0d]", tname, i), got_store_q[i], exp_store_q[i]);
        end
        $display("Test %s finished", tname);
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic test_reset();
        mem_req_t first_req;
        first_req        = '0;
        first_req.rd_stb = 1'b1;
        load_begin();
        addi_instr(5'd1, 5'd0, 16'h0011);
        addi_instr(5'd2, 5'd1, 16'h0022);
        release_reset();
        // First fetch is in this cycle and retires three edges later
        for (int k = 0; k < 3; k++) begin
            @(negedge clk);
            if (k == 0) begin
                check_req("reset mem_req", mem_req, first_req);
            end
            if (retire.valid) begin
                fail_cnt++;
                $display("retire.valid went high %0d cycles after reset, too early", k);
            end
        end
        @(negedge clk);
        if (!retire.valid) begin
            fail_cnt++;
            $display("first instruction did not retire three cycles after its fetch");
        end
        check_results("reset");
    endtask

    task automatic test_alu_chain();
        logic [15:0] imm_a;
        logic [15:0] imm_b;
        imm_a = 16'($urandom());
        imm_b = 16'($urandom());
        load_begin();
        addi_instr(5'd1, 5'd0, imm_a);
        addi_instr(5'd2, 5'd0, imm_b);
        rtype_instr(funct_add, 5'd3, 5'd1, 5'd2);
        rtype_instr(funct_sub, 5'd4, 5'd3, 5'd1);
        rtype_instr(funct_and, 5'd5, 5'd4, 5'd2);
        rtype_instr(funct_or,  5'd6, 5'd5, 5'd3);
        rtype_instr(funct_slt, 5'd7, 5'd6, 5'd4);
        rtype_instr(funct_slt, 5'd8, 5'd4, 5'd6);
        release_reset();
        check_results("alu_chain");
    endtask

    task automatic test_mem_share();
        logic [15:0] imm_v;
        imm_v = 16'($urandom());
        load_begin();
        addi_instr(5'd1, 5'd0, imm_v);
        addi_instr(5'd3, 5'd0, 16'h0400);
        store_instr(5'd1, 5'd3, 16'h0000);
        load_instr(5'd2, 5'd3, 16'h0000);
        store_instr(5'd2, 5'd3, 16'h0008);
        rtype_instr(funct_add, 5'd4, 5'd2, 5'd1);
        release_reset();
        check_results("mem_share");
    endtask

    task automatic test_branch();
        logic [15:0] imm_a;
        imm_a = 16'($urandom());
        load_begin();
        addi_instr(5'd1, 5'd0, imm_a);
        addi_instr(5'd2, 5'd0, imm_a);
        beq_instr(5'd1, 5'd2, 16'd2);
        // Wrong-path instructions that must never retire
        put_word({op_addi, 5'd0, 5'd3, 16'h0bad});
        put_word({op_addi, 5'd0, 5'd4, 16'h0bad});
        addi_instr(5'd5, 5'd0, imm_a + 16'd1);
        beq_instr(5'd1, 5'd5, 16'd1);
        addi_instr(5'd6, 5'd0, 16'h0044);
        release_reset();
        check_results("branch");
    endtask

    task automatic test_jump();
        logic [15:0] imm_a;
        imm_a = 16'($urandom());
        load_begin();
        addi_instr(5'd1, 5'd0, imm_a);
        jump_instr(4);
        put_word({op_addi, 5'd0, 5'd2, 16'h0bad});
        put_word({op_addi, 5'd0, 5'd3, 16'h0bad});
        addi_instr(5'd4, 5'd1, 16'h0007);
        release_reset();
        check_results("jump");
    endtask

    task automatic test_reg_zero();
        logic [15:0] imm_b;
        logic [15:0] imm_c;
        imm_b = 16'($urandom());
        // Nonzero so a write that leaks into r0 changes the sums
        imm_c = 16'($urandom()) | 16'h0001;
        load_begin();
        addi_instr(5'd1, 5'd0, imm_b);
        addi_instr(5'd0, 5'd0, imm_c);
        rtype_instr(funct_add, 5'd2, 5'd0, 5'd1);
        rtype_instr(funct_add, 5'd3, 5'd1, 5'd0);
        release_reset();
        check_results("reg_zero");
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        prog_len     = 0;
        void'($urandom(29));
        for (int i = 0; i < 1024; i++) begin
            mem_words[i] = '0;
        end
        test_reset();
        test_alu_chain();
        test_mem_share();
        test_branch();
        test_jump();
        test_reg_zero();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
